// File: dv/serial_mult_tb.sv
`default_nettype none

module serial_mult_tb;

   localparam int width          = 8;
   localparam int pw             = 2 * width;
   localparam int reset_cycles   = 16;
   localparam int hold_cycles    = 20;
   localparam int random_ops     = 200;
   localparam int op_count       = 5 + random_ops + 1 + 2 + 1;
   localparam int timeout_cycles = op_count * (width + 4) + reset_cycles + hold_cycles + 100;

   logic             clk;
   logic             rst;
   logic             start;
   logic [width-1:0] a;
   logic [width-1:0] b;
   logic             busy;
   logic             done;
   logic [pw-1:0]    product;

   int               cycle_count  = 0;
   int               error_count  = 0;
   int               tests_passed = 0;
   int               tests_failed = 0;
   logic [15:0]      lfsr_state;

   serial_mult #(
      .WIDTH (width)
   ) u_serial_mult (
      .clk     (clk),
      .rst     (rst),
      .start   (start),
      .a       (a),
      .b       (b),
      .busy    (busy),
      .done    (done),
      .product (product)
   );

   // **********************************************************************
   // clock, cycle counter and timeout
   // **********************************************************************

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   initial begin
      wait (cycle_count >= timeout_cycles);
      $display("timeout: no end of tests after %0d cycles", cycle_count);
      $display("sim failed");
      $finish;
   end

   // **********************************************************************
   // helpers
   // **********************************************************************

   // inputs change and outputs are read one unit after the edge.
   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   function automatic logic [15:0] galois_step(input logic [15:0] s);
      logic [15:0] n;
      n = s >> 1;
      if (s[0])
         n = n ^ 16'hB400;                            // taps 16, 14, 13, 11.
      return n;
   endfunction

   task automatic draw_operand(output logic [width-1:0] v);
      int i;
      for (i = 0; i < width; i++) begin
         v[i]       = lfsr_state[0];
         lfsr_state = galois_step(lfsr_state);
      end
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] expected);
      $display("[ERROR] %s: got 0x%h expected 0x%h", sig, got, expected);
      error_count++;
   endtask

   task automatic report_failure(input string what);
      $display("error: %s", what);
      error_count++;
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (error_count == errs_before) begin
         $display("test %s: ok", name);
         tests_passed++;
      end else begin
         $display("test %s: %0d errors", name, error_count - errs_before);
         tests_failed++;
      end
   endtask

   // idle outputs with a given held product.
   task automatic check_quiet(input logic [pw-1:0] held);
      if (busy !== 1'b0)
         report_mismatch("busy", 32'(busy), 32'h0);
      if (done !== 1'b0)
         report_mismatch("done", 32'(done), 32'h0);
      if (product !== held)
         report_mismatch("product", 32'(product), 32'(held));
   endtask

   // one multiplication, ending in the done cycle.
   task automatic run_op(input logic [width-1:0] op_a, input logic [width-1:0] op_b);
      logic [pw-1:0] expected;
      int            k;
      expected = pw'(op_a) * pw'(op_b);
      start    = 1'b1;
      a        = op_a;
      b        = op_b;
      tick();                                         // start taken here.
      start = 1'b0;
      a     = ~op_a;                                  // must not matter now.
      b     = ~op_b;
      for (k = 0; k <= width; k++) begin
         if (busy !== 1'b1)
            report_mismatch("busy", 32'(busy), 32'h1);
         if (done !== 1'b0)
            report_mismatch("done", 32'(done), 32'h0);
         tick();
      end
      if (done !== 1'b1)
         report_mismatch("done", 32'(done), 32'h1);
      if (busy !== 1'b0)
         report_mismatch("busy", 32'(busy), 32'h0);
      if (product !== expected)
         report_mismatch("product", 32'(product), 32'(expected));
   endtask

   // **********************************************************************
   // directed tests
   // **********************************************************************

   task automatic test_reset();
      int errs;
      int k;
      errs = error_count;
      rst  = 1'b1;
      for (k = 0; k < reset_cycles; k++) begin
         tick();
         check_quiet('0);
      end
      rst = 1'b0;
      for (k = 0; k < 2; k++) begin
         tick();
         check_quiet('0);
      end
      finish_test("reset", errs);
   endtask

   task automatic test_corner_operands();
      int errs;
      errs = error_count;
      run_op(8'h00, 8'h5A);
      run_op(8'h5A, 8'h00);
      run_op(8'h01, 8'hB7);
      run_op(8'hFF, 8'hFF);                           // largest product.
      run_op(8'h80, 8'h02);
      finish_test("corner_operands", errs);
   endtask

   task automatic test_random_operands();
      logic [width-1:0] op_a;
      logic [width-1:0] op_b;
      int               errs;
      int               n;
      errs = error_count;
      for (n = 0; n < random_ops; n++) begin
         draw_operand(op_a);
         draw_operand(op_b);
         run_op(op_a, op_b);
      end
      finish_test("random_operands", errs);
   endtask

   task automatic test_start_while_busy();
      logic [pw-1:0] expected;
      int            errs;
      int            k;
      errs     = error_count;
      expected = pw'(8'h3C) * pw'(8'hA5);
      start    = 1'b1;
      a        = 8'h3C;
      b        = 8'hA5;
      tick();
      start = 1'b0;
      a     = 8'hE1;                                  // second operand pair.
      b     = 8'h17;
      for (k = 0; k <= width; k++) begin
         if (busy !== 1'b1)
            report_mismatch("busy", 32'(busy), 32'h1);
         if (done !== 1'b0)
            report_mismatch("done", 32'(done), 32'h0);
         // once mid run, once in the last busy cycle.
         start = (k == 2) || (k == width);
         tick();
      end
      start = 1'b0;
      if (done !== 1'b1)
         report_mismatch("done", 32'(done), 32'h1);
      if (busy !== 1'b0)
         report_mismatch("busy", 32'(busy), 32'h0);
      if (product !== expected)
         report_mismatch("product", 32'(product), 32'(expected));
      for (k = 0; k < width + 3; k++) begin
         tick();
         if (done !== 1'b0 || busy !== 1'b0)
            report_failure("start during busy began a second operation");
      end
      finish_test("start_while_busy", errs);
   endtask

   task automatic test_back_to_back_and_hold();
      logic [pw-1:0] held;
      int            errs;
      int            k;
      errs = error_count;
      run_op(8'hC3, 8'h5E);
      run_op(8'h7F, 8'h81);                           // started in done cycle.
      held = pw'(8'h7F) * pw'(8'h81);
      for (k = 0; k < hold_cycles; k++) begin
         tick();
         check_quiet(held);
      end
      finish_test("back_to_back_and_hold", errs);
   endtask

   // **********************************************************************
   // main sequence
   // **********************************************************************

   initial begin
      clk        = 1'b0;
      rst        = 1'b1;
      start      = 1'b0;
      a          = '0;
      b          = '0;
      lfsr_state = 16'd24852;
      test_reset();
      test_corner_operands();
      test_random_operands();
      test_start_while_busy();
      test_back_to_back_and_hold();
      $display("summary: %0d tests passed, %0d tests failed, %0d errors",
               tests_passed, tests_failed, error_count);
      if (error_count == 0 && tests_failed == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/mult_dims_pkg.sv
`default_nettype none

package mult_dims_pkg;

   // **********************************************************************
   // operand and result dimensions
   // **********************************************************************

   localparam int default_width = 8;                  // operand bits.

   // bits needed to count through the multiplier bits.
   function automatic int step_idx_width(input int width);
      int w;
      w = $clog2(width);
      return (w < 1) ? 1 : w;                         // never below one bit.
   endfunction

   // full product of two unsigned operands.
   function automatic int product_width(input int width);
      return 2 * width;
   endfunction

endpackage

`default_nettype wire

// File: logic/mult_seq_pkg.sv
`default_nettype none

package mult_seq_pkg;

   // **********************************************************************
   // step sequencer states
   // **********************************************************************

   // idle waits for start, run walks the multiplier bits.
   typedef enum logic {
      seq_idle = 1'b0,                                // no operation.
      seq_run  = 1'b1                                 // one step per cycle.
   } seq_state_t;

endpackage

`default_nettype wire

// File: logic/product_assembler.sv
`default_nettype none

module product_assembler #(
   parameter int WIDTH = 8
) (
   input  wire                                              clk,
   input  wire                                              rst,
   input  wire                                              step,
   input  wire                                              last,
   input  wire                                              drop_bit,
   input  wire  [mult_dims_pkg::step_idx_width(WIDTH)-1:0]  step_idx,
   input  wire  [WIDTH-1:0]                                 high_part,
   output logic [mult_dims_pkg::product_width(WIDTH)-1:0]   product,
   output logic                                             done
);

   logic [WIDTH-1:0] low_part;                        // collected low half.
   logic             last_d;                          // final step seen.

   // **********************************************************************
   // low half capture
   // **********************************************************************

   // each step drops exactly one product bit, at its own index.
   always_ff @(posedge clk) begin
      if (step) begin
         low_part[step_idx] <= drop_bit;
      end
   end

   // **********************************************************************
   // result register
   // **********************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         last_d  <= 1'b0;
         done    <= 1'b0;
         product <= '0;
      end else begin
         last_d <= step && last;
         done   <= last_d;                            // single pulse.
         if (last_d) begin
            product <= {high_part, low_part};         // held until next.
         end
      end
   end

endmodule

`default_nettype wire

// File: logic/serial_mult.sv
`default_nettype none

module serial_mult #(
   parameter int WIDTH = mult_dims_pkg::default_width
) (
   input  wire                                              clk,
   input  wire                                              rst,
   input  wire                                              start,
   input  wire  [WIDTH-1:0]                                 a,
   input  wire  [WIDTH-1:0]                                 b,
   output logic                                             busy,
   output logic                                             done,
   output logic [mult_dims_pkg::product_width(WIDTH)-1:0]   product
);

   localparam int idx_w = mult_dims_pkg::step_idx_width(WIDTH);

   // **********************************************************************
   // interconnect
   // **********************************************************************

   logic             load;
   logic             step;
   logic             last;
   logic             mult_bit;
   logic [idx_w-1:0] step_idx;
   logic             drop_bit;
   logic [WIDTH-1:0] high_part;

   // walks the multiplier bits.
   step_sequencer #(
      .WIDTH (WIDTH)
   ) u_step_sequencer (
      .clk      (clk),
      .rst      (rst),
      .start    (start),
      .a        (a),
      .load     (load),
      .step     (step),
      .last     (last),
      .busy     (busy),
      .step_idx (step_idx),
      .mult_bit (mult_bit)
   );

   // accumulates the multiplicand.
   shift_add_stage #(
      .WIDTH (WIDTH)
   ) u_shift_add_stage (
      .clk       (clk),
      .rst       (rst),
      .load      (load),
      .step      (step),
      .mult_bit  (mult_bit),
      .b         (b),
      .drop_bit  (drop_bit),
      .high_part (high_part)
   );

   // joins both halves of the result.
   product_assembler #(
      .WIDTH (WIDTH)
   ) u_product_assembler (
      .clk       (clk),
      .rst       (rst),
      .step      (step),
      .last      (last),
      .drop_bit  (drop_bit),
      .step_idx  (step_idx),
      .high_part (high_part),
      .product   (product),
      .done      (done)
   );

endmodule

`default_nettype wire

// File: logic/shift_add_stage.sv
`default_nettype none

module shift_add_stage #(
   parameter int WIDTH = 8
) (
   input  wire              clk,
   input  wire              rst,
   input  wire              load,
   input  wire              step,
   input  wire              mult_bit,
   input  wire  [WIDTH-1:0] b,
   output logic             drop_bit,
   output logic [WIDTH-1:0] high_part
);

   // **********************************************************************
   // operand and running sum
   // **********************************************************************

   logic [WIDTH-1:0] mcand;                           // stored multiplicand.
   logic [WIDTH-1:0] psum;                            // running partial sum.
   logic [WIDTH-1:0] addend;
   logic [WIDTH:0]   sum;                             // one carry bit on top.

   always_ff @(posedge clk) begin
      if (load) begin
         mcand <= b;
      end
   end

   // **********************************************************************
   // conditional add, then halve
   // **********************************************************************

   always_comb begin
      addend = mult_bit ? mcand : '0;
      sum    = {1'b0, psum} + {1'b0, addend};
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         psum <= '0;
      end else if (load) begin
         psum <= '0;                                  // fresh operation.
      end else if (step) begin
         psum <= sum[WIDTH:1];                        // carry shifts in.
      end
   end

   // lowest sum bit leaves the running sum for good.
   assign drop_bit  = sum[0];
   assign high_part = psum;

endmodule

`default_nettype wire

// File: logic/step_sequencer.sv
`default_nettype none

module step_sequencer #(
   parameter int WIDTH = 8
) (
   input  wire                                              clk,
   input  wire                                              rst,
   input  wire                                              start,
   input  wire  [WIDTH-1:0]                                 a,
   output logic                                             load,
   output logic                                             step,
   output logic                                             last,
   output logic                                             busy,
   output logic [mult_dims_pkg::step_idx_width(WIDTH)-1:0]  step_idx,
   output logic                                             mult_bit
);

   localparam int idx_w = mult_dims_pkg::step_idx_width(WIDTH);

   mult_seq_pkg::seq_state_t state;
   logic [WIDTH-1:0]         mult_reg;                // latched multiplier.
   logic                     finishing;               // result still pending.
   logic                     accept;

   // **********************************************************************
   // start acceptance and status
   // **********************************************************************

   assign accept = start && (state == mult_seq_pkg::seq_idle) && !finishing;
   assign load   = accept;
   assign step   = (state == mult_seq_pkg::seq_run);
   assign busy   = (state == mult_seq_pkg::seq_run) || finishing;

   // multiplier bit for the step in progress.
   assign mult_bit = mult_reg[step_idx];

   always_ff @(posedge clk) begin
      if (accept) begin
         mult_reg <= a;
      end
   end

   // **********************************************************************
   // state machine and step counter
   // **********************************************************************

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= mult_seq_pkg::seq_idle;
         finishing <= 1'b0;
         last      <= 1'b0;
         step_idx  <= '0;
      end else begin
         finishing <= 1'b0;                           // one cycle only.
         case (state)
            mult_seq_pkg::seq_idle: begin
               if (accept) begin
                  state    <= mult_seq_pkg::seq_run;
                  step_idx <= '0;
                  last     <= 1'b0;                   // WIDTH is at least 2.
               end
            end
            mult_seq_pkg::seq_run: begin
               if (last) begin
                  state     <= mult_seq_pkg::seq_idle;
                  finishing <= 1'b1;
                  last      <= 1'b0;
                  step_idx  <= '0;
               end else begin
                  step_idx <= step_idx + 1'b1;
                  last     <= (step_idx == idx_w'(WIDTH - 2));
               end
            end
            default: begin
               state <= mult_seq_pkg::seq_idle;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the serial_mult testbench with Verilator.
# The result is taken from the simulation log.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f serial_mult.f \
   --top-module serial_mult_tb -o serial_mult_sim \
   && ./obj_dir/serial_mult_sim | tee sim.log \
   && grep -q "^sim passed$" sim.log \
   && echo "RESULT: PASS" \
   || { echo "RESULT: FAIL"; exit 1; }

// File: serial_mult.f
logic/mult_dims_pkg.sv
logic/mult_seq_pkg.sv
logic/shift_add_stage.sv
logic/step_sequencer.sv
logic/product_assembler.sv
logic/serial_mult.sv
dv/serial_mult_tb.sv
